/* Bender.yml */
package:
  name: exu_decode

sources:
  - include_dirs:
      - .
    files:
      - exu_decode_pkg.sv
      - dec_opcode_class.sv
      - dec_imm_gen.sv
      - dec_regidx.sv
      - dec_info_pack.sv
      - exu_decode.sv
  - target: test
    include_dirs:
      - .
    files:
      - exu_decode_checker.sv
      - exu_decode_scoreboard.sv
      - exu_decode_tb.sv

/* all.f */
+incdir+.
exu_decode_pkg.sv
dec_opcode_class.sv
dec_imm_gen.sv
dec_regidx.sv
dec_info_pack.sv
exu_decode.sv
exu_decode_checker.sv
exu_decode_scoreboard.sv
exu_decode_tb.sv

/* dec_imm_gen.sv */
`timescale 1ns/1ps
`include "exu_decode_config.svh"

module dec_imm_gen (
  input  exu_decode_pkg::instr_t   i_instr,
  input  exu_decode_pkg::opclass_t i_class,
  output exu_decode_pkg::xlen_t    o_imm,
  output logic                     o_need_imm
);

  import exu_decode_pkg::*;

  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  logic  sel_i;
  logic  sel_s;
  logic  sel_b;
  logic  sel_u;
  logic  sel_j;

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                  i_instr[30:25], i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                  i_instr[20], i_instr[30:21], 1'b0};

  assign sel_i = i_class.op_imm | i_class.jalr | i_class.load;
  assign sel_s = i_class.store;
  assign sel_b = i_class.branch;
  assign sel_u = i_class.lui | i_class.auipc;
  assign sel_j = i_class.jal;

  // selects are one-hot, so and-or is enough
  assign o_imm = ({`EXU_XLEN{sel_i}} & imm_i)
               | ({`EXU_XLEN{sel_s}} & imm_s)
               | ({`EXU_XLEN{sel_b}} & imm_b)
               | ({`EXU_XLEN{sel_u}} & imm_u)
               | ({`EXU_XLEN{sel_j}} & imm_j);

  assign o_need_imm = sel_i | sel_s | sel_b | sel_u | sel_j;

endmodule

/* dec_info_pack.sv */
`timescale 1ns/1ps
`include "exu_decode_config.svh"

module dec_info_pack (
  input  exu_decode_pkg::instr_t    i_instr,
  input  exu_decode_pkg::opclass_t  i_class,
  input  logic [7:0]                i_func3_sel,
  input  logic                      i_alt,
  input  logic                      i_muldiv,
  input  logic                      i_func7_zero,
  input  logic [11:0]               i_sys_code,
  input  logic                      i_need_imm,
  input  logic                      i_prdt_taken,
  input  logic                      i_dbg_mode,
  output exu_decode_pkg::dec_info_t o_info,
  output logic                      o_ilegl,
  output logic                      o_csr_imm
);

  import exu_decode_pkg::*;

  logic [7:0] f3;
  logic       sys_priv;
  logic       ecall, ebreak, mret, dret, wfi;
  logic       slli, srli, srai, shamt_ilgl;
  logic       op_base, nop;
  logic       alu_op, agu_op, bjp_op, csr_op, muldiv_op;
  dec_info_t  alu_bus, agu_bus, bjp_bus, csr_bus, muldiv_bus;

  assign f3       = i_func3_sel;
  assign op_base  = i_class.op & ~i_muldiv;
  assign sys_priv = i_class.system & f3[0];
  assign ecall    = sys_priv & (i_sys_code == `EXU_SYS_ECALL);
  assign ebreak   = sys_priv & (i_sys_code == `EXU_SYS_EBREAK);
  assign mret     = sys_priv & (i_sys_code == `EXU_SYS_MRET);
  assign dret     = sys_priv & (i_sys_code == `EXU_SYS_DRET);
  assign wfi      = sys_priv & (i_sys_code == `EXU_SYS_WFI);

  assign slli = i_class.op_imm & f3[1] & (i_instr[31:26] == 6'b000000);
  assign srli = i_class.op_imm & f3[5] & (i_instr[31:26] == 6'b000000);
  assign srai = i_class.op_imm & f3[5] & (i_instr[31:26] == 6'b010000);
  assign shamt_ilgl = (slli | srli | srai) & i_instr[25]; // shamt[5] on rv32
  assign nop  = i_class.op_imm & f3[0] & (i_instr[31:7] == '0);

  always_comb begin
    alu_bus = '0;
    alu_bus[`EXU_DECINFO_GRP]        = GRP_ALU;
    alu_bus[`EXU_DECINFO_ALU_ADD]    = (op_base & f3[0] & i_func7_zero)
                                     | (i_class.op_imm & f3[0]) | i_class.auipc;
    alu_bus[`EXU_DECINFO_ALU_SUB]    = op_base & f3[0] & i_alt;
    alu_bus[`EXU_DECINFO_ALU_XOR]    = (op_base & f3[4] & i_func7_zero) | (i_class.op_imm & f3[4]);
    alu_bus[`EXU_DECINFO_ALU_SLL]    = (op_base & f3[1] & i_func7_zero) | slli;
    alu_bus[`EXU_DECINFO_ALU_SRL]    = (op_base & f3[5] & i_func7_zero) | srli;
    alu_bus[`EXU_DECINFO_ALU_SRA]    = (op_base & f3[5] & i_alt) | srai;
    alu_bus[`EXU_DECINFO_ALU_OR]     = (op_base & f3[6] & i_func7_zero) | (i_class.op_imm & f3[6]);
    alu_bus[`EXU_DECINFO_ALU_AND]    = (op_base & f3[7] & i_func7_zero) | (i_class.op_imm & f3[7]);
    alu_bus[`EXU_DECINFO_ALU_SLT]    = (op_base & f3[2] & i_func7_zero) | (i_class.op_imm & f3[2]);
    alu_bus[`EXU_DECINFO_ALU_SLTU]   = (op_base & f3[3] & i_func7_zero) | (i_class.op_imm & f3[3]);
    alu_bus[`EXU_DECINFO_ALU_LUI]    = i_class.lui;
    alu_bus[`EXU_DECINFO_ALU_OP2IMM] = i_need_imm;
    alu_bus[`EXU_DECINFO_ALU_OP1PC]  = i_class.auipc;
    alu_bus[`EXU_DECINFO_ALU_NOP]    = nop;
    alu_bus[`EXU_DECINFO_ALU_ECAL]   = ecall;
    alu_bus[`EXU_DECINFO_ALU_EBRK]   = ebreak;
    alu_bus[`EXU_DECINFO_ALU_WFI]    = wfi;
  end

  always_comb begin
    agu_bus = '0;
    agu_bus[`EXU_DECINFO_GRP]        = GRP_AGU;
    agu_bus[`EXU_DECINFO_AGU_LOAD]   = i_class.load;
    agu_bus[`EXU_DECINFO_AGU_STORE]  = i_class.store;
    agu_bus[`EXU_DECINFO_AGU_SIZE]   = i_instr[13:12];
    agu_bus[`EXU_DECINFO_AGU_USIGN]  = i_instr[14];
    agu_bus[`EXU_DECINFO_AGU_OP2IMM] = i_need_imm;
  end

  always_comb begin
    bjp_bus = '0;
    bjp_bus[`EXU_DECINFO_GRP]        = GRP_BJP;
    bjp_bus[`EXU_DECINFO_BJP_JUMP]   = i_class.jal | i_class.jalr;
    bjp_bus[`EXU_DECINFO_BJP_BPRDT]  = i_prdt_taken;
    bjp_bus[`EXU_DECINFO_BJP_BEQ]    = i_class.branch & f3[0];
    bjp_bus[`EXU_DECINFO_BJP_BNE]    = i_class.branch & f3[1];
    bjp_bus[`EXU_DECINFO_BJP_BLT]    = i_class.branch & f3[4];
    bjp_bus[`EXU_DECINFO_BJP_BGT]    = i_class.branch & f3[5];
    bjp_bus[`EXU_DECINFO_BJP_BLTU]   = i_class.branch & f3[6];
    bjp_bus[`EXU_DECINFO_BJP_BGTU]   = i_class.branch & f3[7];
    bjp_bus[`EXU_DECINFO_BJP_BXX]    = i_class.branch;
    bjp_bus[`EXU_DECINFO_BJP_MRET]   = mret;
    bjp_bus[`EXU_DECINFO_BJP_DRET]   = dret;
    bjp_bus[`EXU_DECINFO_BJP_FENCE]  = i_class.miscmem & f3[0];
    bjp_bus[`EXU_DECINFO_BJP_FENCEI] = i_class.miscmem & f3[1];
  end

  assign o_csr_imm = i_class.system & (f3[5] | f3[6] | f3[7]);

  always_comb begin
    csr_bus = '0;
    csr_bus[`EXU_DECINFO_GRP]        = GRP_CSR;
    csr_bus[`EXU_DECINFO_CSR_OP]     = i_instr[13:12];
    csr_bus[`EXU_DECINFO_CSR_RS1IMM] = o_csr_imm;
    csr_bus[`EXU_DECINFO_CSR_ZIMM]   = i_instr[19:15];
    csr_bus[`EXU_DECINFO_CSR_RS1IS0] = (i_instr[19:15] == 5'd0);
    csr_bus[`EXU_DECINFO_CSR_CSRIDX] = i_instr[31:20];
  end

  always_comb begin
    muldiv_bus = '0;
    muldiv_bus[`EXU_DECINFO_GRP]           = GRP_MULDIV;
    muldiv_bus[`EXU_DECINFO_MULDIV_MUL]    = f3[0];
    muldiv_bus[`EXU_DECINFO_MULDIV_MULH]   = f3[1];
    muldiv_bus[`EXU_DECINFO_MULDIV_MULHSU] = f3[2];
    muldiv_bus[`EXU_DECINFO_MULDIV_MULHU]  = f3[3];
    muldiv_bus[`EXU_DECINFO_MULDIV_DIV]    = f3[4];
    muldiv_bus[`EXU_DECINFO_MULDIV_DIVU]   = f3[5];
    muldiv_bus[`EXU_DECINFO_MULDIV_REM]    = f3[6];
    muldiv_bus[`EXU_DECINFO_MULDIV_REMU]   = f3[7];
  end

  assign alu_op = ~shamt_ilgl & (i_class.op_imm | op_base | i_class.auipc | i_class.lui
                                 | wfi | ecall | ebreak);
  assign agu_op    = i_class.load | i_class.store;
  assign bjp_op    = i_class.jal | i_class.jalr | i_class.branch | mret
                   | (dret & i_dbg_mode) | (i_class.miscmem & (f3[0] | f3[1]));
  assign csr_op    = i_class.system & ~f3[0] & ~f3[4]; // func3 100 is reserved
  assign muldiv_op = i_class.op & i_muldiv;

  // at most one op term is set
  assign o_info = ({`EXU_DECINFO_WIDTH{alu_op}}    & alu_bus)
                | ({`EXU_DECINFO_WIDTH{agu_op}}    & agu_bus)
                | ({`EXU_DECINFO_WIDTH{bjp_op}}    & bjp_bus)
                | ({`EXU_DECINFO_WIDTH{csr_op}}    & csr_bus)
                | ({`EXU_DECINFO_WIDTH{muldiv_op}} & muldiv_bus);

  assign o_ilegl = (i_instr == '0)
                 | (&i_instr)
                 | shamt_ilgl
                 | (dret & ~i_dbg_mode)
                 | ~(alu_op | agu_op | bjp_op | csr_op | muldiv_op);

endmodule

/* dec_opcode_class.sv */
`timescale 1ns/1ps

module dec_opcode_class (
  input  exu_decode_pkg::instr_t   i_instr,
  output exu_decode_pkg::opclass_t o_class,
  output logic [7:0]               o_func3_sel,
  output logic                     o_alt,
  output logic                     o_muldiv,
  output logic                     o_func7_zero,
  output logic [11:0]              o_sys_code
);

  logic [1:0] op_6_5;
  logic [2:0] op_4_2;
  logic       op_1_0_11;
  logic [6:0] func7;

  assign op_6_5    = i_instr[6:5];
  assign op_4_2    = i_instr[4:2];
  assign op_1_0_11 = (i_instr[1:0] == 2'b11); // anything else is not a 32-bit op
  assign func7     = i_instr[31:25];

  always_comb begin
    o_class = '0;
    if (op_1_0_11) begin
      case ({op_6_5, op_4_2})
        5'b00_000: o_class.load    = 1'b1;
        5'b01_000: o_class.store   = 1'b1;
        5'b11_000: o_class.branch  = 1'b1;
        5'b11_001: o_class.jalr    = 1'b1;
        5'b11_011: o_class.jal     = 1'b1;
        5'b00_011: o_class.miscmem = 1'b1;
        5'b00_100: o_class.op_imm  = 1'b1;
        5'b01_100: o_class.op      = 1'b1;
        5'b11_100: o_class.system  = 1'b1;
        5'b00_101: o_class.auipc   = 1'b1;
        5'b01_101: o_class.lui     = 1'b1;
        default:   o_class         = '0; // fp, amo, custom, reserved
      endcase
    end
  end

  // func3 decoded once, shared downstream
  assign o_func3_sel  = 8'b0000_0001 << i_instr[14:12];
  assign o_alt        = (func7 == 7'b0100000);
  assign o_muldiv     = (func7 == 7'b0000001);
  assign o_func7_zero = (func7 == 7'b0000000);
  assign o_sys_code   = i_instr[31:20];

endmodule

/* dec_regidx.sv */
`timescale 1ns/1ps

module dec_regidx (
  input  exu_decode_pkg::instr_t   i_instr,
  input  exu_decode_pkg::opclass_t i_class,
  input  logic                     i_csr_imm,
  output exu_decode_pkg::rfidx_t   o_rs1idx,
  output exu_decode_pkg::rfidx_t   o_rs2idx,
  output exu_decode_pkg::rfidx_t   o_rdidx,
  output logic                     o_rs1en,
  output logic                     o_rs2en,
  output logic                     o_rdwen
);

  logic sys_priv; // ecall/ebreak/mret/dret/wfi
  logic rs1_x0;
  logic rs2_x0;
  logic rd_x0;

  // rv32 only, fields sit at fixed positions
  assign o_rs1idx = i_instr[19:15];
  assign o_rs2idx = i_instr[24:20];
  assign o_rdidx  = i_instr[11:7];

  assign rs1_x0   = (o_rs1idx == '0);
  assign rs2_x0   = (o_rs2idx == '0);
  assign rd_x0    = (o_rdidx == '0);
  assign sys_priv = i_class.system & (i_instr[14:12] == 3'b000);

  assign o_rdwen = ~rd_x0
                 & ~i_class.branch
                 & ~i_class.store
                 & ~i_class.miscmem
                 & ~sys_priv;

  assign o_rs1en = ~rs1_x0
                 & ~i_class.lui
                 & ~i_class.auipc
                 & ~i_class.jal
                 & ~i_class.miscmem
                 & ~sys_priv
                 & ~i_csr_imm;  // zimm sits in the rs1 field

  assign o_rs2en = ~rs2_x0 & (i_class.branch | i_class.store | i_class.op);

endmodule

/* exu_decode.sv */
`timescale 1ns/1ps

module exu_decode (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  exu_decode_pkg::instr_t    i_instr,
  input  exu_decode_pkg::pc_t       i_pc,
  input  logic                      i_prdt_taken,
  input  logic                      i_dbg_mode,
  output logic                      o_valid,
  output exu_decode_pkg::pc_t       o_pc,
  output exu_decode_pkg::dec_info_t o_info,
  output exu_decode_pkg::xlen_t     o_imm,
  output exu_decode_pkg::rfidx_t    o_rs1idx,
  output exu_decode_pkg::rfidx_t    o_rs2idx,
  output exu_decode_pkg::rfidx_t    o_rdidx,
  output logic                      o_rs1en,
  output logic                      o_rs2en,
  output logic                      o_rdwen,
  output logic                      o_ilegl
);

  import exu_decode_pkg::*;

  opclass_t   cls;
  logic [7:0] func3_sel;
  logic       alt;
  logic       muldiv;
  logic       func7_zero;
  logic [11:0] sys_code;
  xlen_t      imm;
  logic       need_imm;
  logic       csr_imm;
  rfidx_t     rs1idx;
  rfidx_t     rs2idx;
  rfidx_t     rdidx;
  logic       rs1en;
  logic       rs2en;
  logic       rdwen;
  dec_info_t  info;
  logic       ilegl;

  dec_opcode_class u_class (
    .i_instr      (i_instr),
    .o_class      (cls),
    .o_func3_sel  (func3_sel),
    .o_alt        (alt),
    .o_muldiv     (muldiv),
    .o_func7_zero (func7_zero),
    .o_sys_code   (sys_code)
  );

  dec_imm_gen u_imm (
    .i_instr    (i_instr),
    .i_class    (cls),
    .o_imm      (imm),
    .o_need_imm (need_imm)
  );

  dec_regidx u_regidx (
    .i_instr   (i_instr),
    .i_class   (cls),
    .i_csr_imm (csr_imm),
    .o_rs1idx  (rs1idx),
    .o_rs2idx  (rs2idx),
    .o_rdidx   (rdidx),
    .o_rs1en   (rs1en),
    .o_rs2en   (rs2en),
    .o_rdwen   (rdwen)
  );

  dec_info_pack u_info (
    .i_instr      (i_instr),
    .i_class      (cls),
    .i_func3_sel  (func3_sel),
    .i_alt        (alt),
    .i_muldiv     (muldiv),
    .i_func7_zero (func7_zero),
    .i_sys_code   (sys_code),
    .i_need_imm   (need_imm),
    .i_prdt_taken (i_prdt_taken),
    .i_dbg_mode   (i_dbg_mode),
    .o_info       (info),
    .o_ilegl      (ilegl),
    .o_csr_imm    (csr_imm)
  );

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid; // no back-pressure
    end
  end

  // decode results, held while no new instruction
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc     <= '0;
      o_info   <= '0;
      o_imm    <= '0;
      o_rs1idx <= '0;
      o_rs2idx <= '0;
      o_rdidx  <= '0;
      o_rs1en  <= 1'b0;
      o_rs2en  <= 1'b0;
      o_rdwen  <= 1'b0;
      o_ilegl  <= 1'b0;
    end else if (i_valid) begin
      o_pc     <= i_pc;
      o_info   <= info;
      o_imm    <= imm;
      o_rs1idx <= rs1idx;
      o_rs2idx <= rs2idx;
      o_rdidx  <= rdidx;
      o_rs1en  <= rs1en;
      o_rs2en  <= rs2en;
      o_rdwen  <= rdwen;
      o_ilegl  <= ilegl;
    end
  end

endmodule

/* exu_decode_checker.sv */
`timescale 1ns/1ps
`include "exu_decode_config.svh"

module exu_decode_checker (
  input logic                      clk,
  input logic                      i_rst_n,
  input logic                      o_valid,
  input exu_decode_pkg::dec_info_t o_info,
  input exu_decode_pkg::rfidx_t    o_rs1idx,
  input logic                      o_rs1en,
  input logic                      o_ilegl
);

  import exu_decode_pkg::*;

  int n_fail = 0; // read by the testbench top

  a_valid_in_reset: assert property (@(posedge clk) !i_rst_n |-> !o_valid)
    else begin
      $error("o_valid high while reset is asserted");
      n_fail++;
    end

  // x0 is never read
  a_rs1en_nonzero: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_rs1en |-> (o_rs1idx != '0))
    else begin
      $error("o_rs1en set with rs1 index zero");
      n_fail++;
    end

  a_legal_grp: assert property (@(posedge clk) disable iff (!i_rst_n)
    !o_ilegl |-> (o_info[`EXU_DECINFO_GRP] <= GRP_MULDIV))
    else begin
      $error("legal instruction carries an unknown group code");
      n_fail++;
    end

endmodule

bind exu_decode exu_decode_checker u_chk (
  .clk      (clk),
  .i_rst_n  (i_rst_n),
  .o_valid  (o_valid),
  .o_info   (o_info),
  .o_rs1idx (o_rs1idx),
  .o_rs1en  (o_rs1en),
  .o_ilegl  (o_ilegl)
);

/* exu_decode_config.svh */
`ifndef EXU_DECODE_CONFIG_SVH
`define EXU_DECODE_CONFIG_SVH

`define EXU_XLEN              32
`define EXU_PC_SIZE           32
`define EXU_RFIDX_WIDTH       5

// merged info bus, group code sits in the low bits
`define EXU_DECINFO_WIDTH     24
`define EXU_DECINFO_GRP_WIDTH 3
`define EXU_DECINFO_GRP       2:0

`define EXU_DECINFO_ALU_ADD    3
`define EXU_DECINFO_ALU_SUB    4
`define EXU_DECINFO_ALU_XOR    5
`define EXU_DECINFO_ALU_SLL    6
`define EXU_DECINFO_ALU_SRL    7
`define EXU_DECINFO_ALU_SRA    8
`define EXU_DECINFO_ALU_OR     9
`define EXU_DECINFO_ALU_AND    10
`define EXU_DECINFO_ALU_SLT    11
`define EXU_DECINFO_ALU_SLTU   12
`define EXU_DECINFO_ALU_LUI    13
`define EXU_DECINFO_ALU_OP2IMM 14
`define EXU_DECINFO_ALU_OP1PC  15
`define EXU_DECINFO_ALU_NOP    16
`define EXU_DECINFO_ALU_ECAL   17
`define EXU_DECINFO_ALU_EBRK   18
`define EXU_DECINFO_ALU_WFI    19

`define EXU_DECINFO_AGU_LOAD   3
`define EXU_DECINFO_AGU_STORE  4
`define EXU_DECINFO_AGU_SIZE   6:5
`define EXU_DECINFO_AGU_USIGN  7
`define EXU_DECINFO_AGU_OP2IMM 8

`define EXU_DECINFO_BJP_JUMP   3
`define EXU_DECINFO_BJP_BPRDT  4
`define EXU_DECINFO_BJP_BEQ    5
`define EXU_DECINFO_BJP_BNE    6
`define EXU_DECINFO_BJP_BLT    7
`define EXU_DECINFO_BJP_BGT    8
`define EXU_DECINFO_BJP_BLTU   9
`define EXU_DECINFO_BJP_BGTU   10
`define EXU_DECINFO_BJP_BXX    11
`define EXU_DECINFO_BJP_MRET   12
`define EXU_DECINFO_BJP_DRET   13
`define EXU_DECINFO_BJP_FENCE  14
`define EXU_DECINFO_BJP_FENCEI 15

// csr op is func3[1:0]: 01 rw, 10 rs, 11 rc
`define EXU_DECINFO_CSR_OP     4:3
`define EXU_DECINFO_CSR_RS1IMM 5
`define EXU_DECINFO_CSR_ZIMM   10:6
`define EXU_DECINFO_CSR_RS1IS0 11
`define EXU_DECINFO_CSR_CSRIDX 23:12

`define EXU_DECINFO_MULDIV_MUL    3
`define EXU_DECINFO_MULDIV_MULH   4
`define EXU_DECINFO_MULDIV_MULHSU 5
`define EXU_DECINFO_MULDIV_MULHU  6
`define EXU_DECINFO_MULDIV_DIV    7
`define EXU_DECINFO_MULDIV_DIVU   8
`define EXU_DECINFO_MULDIV_REM    9
`define EXU_DECINFO_MULDIV_REMU   10

// instr[31:20] of the func3 000 system ops
`define EXU_SYS_ECALL  12'h000
`define EXU_SYS_EBREAK 12'h001
`define EXU_SYS_MRET   12'h302
`define EXU_SYS_DRET   12'h7b2
`define EXU_SYS_WFI    12'h105

`endif

/* exu_decode_pkg.sv */
`include "exu_decode_config.svh"

package exu_decode_pkg;

  typedef logic [31:0]                   instr_t;
  typedef logic [`EXU_RFIDX_WIDTH-1:0]   rfidx_t;
  typedef logic [`EXU_XLEN-1:0]          xlen_t;
  typedef logic [`EXU_PC_SIZE-1:0]       pc_t;
  typedef logic [`EXU_DECINFO_WIDTH-1:0] dec_info_t;

  // group code in the low bits of the info bus
  typedef enum logic [`EXU_DECINFO_GRP_WIDTH-1:0] {
    GRP_ALU    = 3'd0,
    GRP_AGU    = 3'd1,
    GRP_BJP    = 3'd2,
    GRP_CSR    = 3'd3,
    GRP_MULDIV = 3'd4
  } dec_grp_e;

  // one-hot, all zero for reserved/custom opcodes
  typedef struct packed {
    logic load;
    logic store;
    logic branch;
    logic jalr;
    logic jal;
    logic miscmem;
    logic op_imm;
    logic op;
    logic system;
    logic auipc;
    logic lui;
  } opclass_t;

endpackage

/* exu_decode_scoreboard.sv */
`timescale 1ns/1ps
`include "exu_decode_config.svh"

module exu_decode_scoreboard (
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_valid,
  input  exu_decode_pkg::instr_t    i_instr,
  input  exu_decode_pkg::pc_t       i_pc,
  input  logic                      i_prdt_taken,
  input  logic                      i_dbg_mode,
  input  logic                      o_valid,
  input  exu_decode_pkg::pc_t       o_pc,
  input  exu_decode_pkg::dec_info_t o_info,
  input  exu_decode_pkg::xlen_t     o_imm,
  input  exu_decode_pkg::rfidx_t    o_rs1idx,
  input  exu_decode_pkg::rfidx_t    o_rs2idx,
  input  exu_decode_pkg::rfidx_t    o_rdidx,
  input  logic                      o_rs1en,
  input  logic                      o_rs2en,
  input  logic                      o_rdwen,
  input  logic                      o_ilegl,
  output int                        o_errors,
  output int                        o_checks
);

  import exu_decode_pkg::*;

  logic      e_valid = 1'b0;
  pc_t       e_pc = '0;
  dec_info_t e_info = '0;
  xlen_t     e_imm = '0;
  logic      e_rs1en = 1'b0;
  logic      e_rs2en = 1'b0;
  logic      e_rdwen = 1'b0;
  logic      e_ilegl = 1'b0;
  instr_t    e_instr = '0; // idx fields come straight from this

  initial begin
    o_errors = 0;
    o_checks = 0;
  end

  // reference decode, written from the ISA encoding
  task automatic decode_ref(input instr_t w, input logic prdt, input logic dbg);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic ld, st, br, jr, jl, mm, oi, op, sy, au, lu;
    logic sys0, csrimm, base, rr, shl, shr, sha, bad_sh, need;
    logic alu, agu, bjp, csr, md, dr;
    opc = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    ld = opc == 7'h03;
    st = opc == 7'h23;
    br = opc == 7'h63;
    jr = opc == 7'h67;
    jl = opc == 7'h6f;
    mm = opc == 7'h0f;
    oi = opc == 7'h13;
    op = opc == 7'h33;
    sy = opc == 7'h73;
    au = opc == 7'h17;
    lu = opc == 7'h37;
    e_imm = '0;
    if (oi || jr || ld) e_imm = {{20{w[31]}}, w[31:20]};
    if (st) e_imm = {{20{w[31]}}, w[31:25], w[11:7]};
    if (br) e_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (lu || au) e_imm = {w[31:12], 12'h000};
    if (jl) e_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    need   = oi | jr | ld | st | br | lu | au | jl;
    sys0   = sy && f3 == 3'd0;
    csrimm = sy && f3[2] && f3[1:0] != 2'b00;
    e_rdwen = w[11:7] != 0 && !br && !st && !mm && !sys0;
    e_rs1en = w[19:15] != 0 && !lu && !au && !jl && !mm && !sys0 && !csrimm;
    e_rs2en = w[24:20] != 0 && (br || st || op);
    shl    = oi && f3 == 3'd1 && w[31:26] == 6'h00;
    shr    = oi && f3 == 3'd5 && w[31:26] == 6'h00;
    sha    = oi && f3 == 3'd5 && w[31:26] == 6'h10;
    bad_sh = (shl || shr || sha) && w[25];
    base   = op && f7 != 7'h01;
    rr     = base && f7 == 7'h00;
    dr     = sys0 && w[31:20] == `EXU_SYS_DRET;
    alu = !bad_sh && (oi || base || au || lu || (sys0 && (w[31:20] == `EXU_SYS_ECALL
          || w[31:20] == `EXU_SYS_EBREAK || w[31:20] == `EXU_SYS_WFI)));
    agu = ld || st;
    bjp = jl || jr || br || (sys0 && w[31:20] == `EXU_SYS_MRET) || (dr && dbg)
          || (mm && f3[2:1] == 2'b00);
    csr = sy && f3 != 3'd0 && f3 != 3'd4;
    md  = op && f7 == 7'h01;
    e_info = '0;
    if (alu) begin
      e_info[`EXU_DECINFO_ALU_ADD]    = (rr && f3 == 0) || (oi && f3 == 0) || au;
      e_info[`EXU_DECINFO_ALU_SUB]    = base && f3 == 0 && f7 == 7'h20;
      e_info[`EXU_DECINFO_ALU_XOR]    = (rr || oi) && f3 == 4;
      e_info[`EXU_DECINFO_ALU_SLL]    = (rr && f3 == 1) || shl;
      e_info[`EXU_DECINFO_ALU_SRL]    = (rr && f3 == 5) || shr;
      e_info[`EXU_DECINFO_ALU_SRA]    = (base && f3 == 5 && f7 == 7'h20) || sha;
      e_info[`EXU_DECINFO_ALU_OR]     = (rr || oi) && f3 == 6;
      e_info[`EXU_DECINFO_ALU_AND]    = (rr || oi) && f3 == 7;
      e_info[`EXU_DECINFO_ALU_SLT]    = (rr || oi) && f3 == 2;
      e_info[`EXU_DECINFO_ALU_SLTU]   = (rr || oi) && f3 == 3;
      e_info[`EXU_DECINFO_ALU_LUI]    = lu;
      e_info[`EXU_DECINFO_ALU_OP2IMM] = need;
      e_info[`EXU_DECINFO_ALU_OP1PC]  = au;
      e_info[`EXU_DECINFO_ALU_NOP]    = oi && f3 == 0 && w[31:7] == 0;
      e_info[`EXU_DECINFO_ALU_ECAL]   = sys0 && w[31:20] == `EXU_SYS_ECALL;
      e_info[`EXU_DECINFO_ALU_EBRK]   = sys0 && w[31:20] == `EXU_SYS_EBREAK;
      e_info[`EXU_DECINFO_ALU_WFI]    = sys0 && w[31:20] == `EXU_SYS_WFI;
    end else if (agu) begin
      e_info[`EXU_DECINFO_GRP]        = GRP_AGU;
      e_info[`EXU_DECINFO_AGU_LOAD]   = ld;
      e_info[`EXU_DECINFO_AGU_STORE]  = st;
      e_info[`EXU_DECINFO_AGU_SIZE]   = f3[1:0];
      e_info[`EXU_DECINFO_AGU_USIGN]  = f3[2];
      e_info[`EXU_DECINFO_AGU_OP2IMM] = 1'b1;
    end else if (bjp) begin
      e_info[`EXU_DECINFO_GRP]        = GRP_BJP;
      e_info[`EXU_DECINFO_BJP_JUMP]   = jl || jr;
      e_info[`EXU_DECINFO_BJP_BPRDT]  = prdt;
      e_info[`EXU_DECINFO_BJP_BEQ]    = br && f3 == 0;
      e_info[`EXU_DECINFO_BJP_BNE]    = br && f3 == 1;
      e_info[`EXU_DECINFO_BJP_BLT]    = br && f3 == 4;
      e_info[`EXU_DECINFO_BJP_BGT]    = br && f3 == 5;
      e_info[`EXU_DECINFO_BJP_BLTU]   = br && f3 == 6;
      e_info[`EXU_DECINFO_BJP_BGTU]   = br && f3 == 7;
      e_info[`EXU_DECINFO_BJP_BXX]    = br;
      e_info[`EXU_DECINFO_BJP_MRET]   = sys0 && w[31:20] == `EXU_SYS_MRET;
      e_info[`EXU_DECINFO_BJP_DRET]   = dr;
      e_info[`EXU_DECINFO_BJP_FENCE]  = mm && f3 == 0;
      e_info[`EXU_DECINFO_BJP_FENCEI] = mm && f3 == 1;
    end else if (csr) begin
      e_info[`EXU_DECINFO_GRP]        = GRP_CSR;
      e_info[`EXU_DECINFO_CSR_OP]     = f3[1:0];
      e_info[`EXU_DECINFO_CSR_RS1IMM] = csrimm;
      e_info[`EXU_DECINFO_CSR_ZIMM]   = w[19:15];
      e_info[`EXU_DECINFO_CSR_RS1IS0] = w[19:15] == 0;
      e_info[`EXU_DECINFO_CSR_CSRIDX] = w[31:20];
    end else if (md) begin
      e_info[`EXU_DECINFO_GRP] = GRP_MULDIV;
      e_info[`EXU_DECINFO_MULDIV_MUL + f3] = 1'b1; // op bits follow func3 order
    end
    e_ilegl = w == 0 || &w || bad_sh || (dr && !dbg) || !(alu || agu || bjp || csr || md);
  endtask

  always @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      e_valid = 1'b0;
      e_pc    = '0;
      e_info  = '0;
      e_imm   = '0;
      e_rs1en = 1'b0;
      e_rs2en = 1'b0;
      e_rdwen = 1'b0;
      e_ilegl = 1'b0;
      e_instr = '0;
    end else begin
      e_valid = i_valid;
      if (i_valid) begin
        decode_ref(i_instr, i_prdt_taken, i_dbg_mode);
        e_pc    = i_pc;
        e_instr = i_instr;
      end
    end
  end

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    o_checks++;
    if (got !== exp) begin
      o_errors++;
      $display("CHECK FAILED @ %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // outputs settle after the rising edge
  always @(negedge clk) begin
    compare_field("o_valid", o_valid, e_valid);
    compare_field("o_pc", o_pc, e_pc);
    compare_field("o_info", o_info, e_info);
    compare_field("o_imm", o_imm, e_imm);
    compare_field("o_rs1idx", o_rs1idx, e_instr[19:15]);
    compare_field("o_rs2idx", o_rs2idx, e_instr[24:20]);
    compare_field("o_rdidx", o_rdidx, e_instr[11:7]);
    compare_field("o_rs1en", o_rs1en, e_rs1en);
    compare_field("o_rs2en", o_rs2en, e_rs2en);
    compare_field("o_rdwen", o_rdwen, e_rdwen);
    compare_field("o_ilegl", o_ilegl, e_ilegl);
  end

endmodule

/* exu_decode_tb.sv */
`timescale 1ns/1ps

module exu_decode_tb;

  import exu_decode_pkg::*;

  localparam int N_TESTS    = 7;
  localparam int N_PER      = 500;
  localparam int TIMEOUT_NS = (N_TESTS * (N_PER + 4) + 20) * 8 + 400;

  logic      clk = 1'b0;
  logic      i_rst_n;
  logic      i_valid;
  instr_t    i_instr;
  pc_t       i_pc;
  logic      i_prdt_taken;
  logic      i_dbg_mode;
  logic      o_valid, o_rs1en, o_rs2en, o_rdwen, o_ilegl;
  pc_t       o_pc;
  dec_info_t o_info;
  xlen_t     o_imm;
  rfidx_t    o_rs1idx, o_rs2idx, o_rdidx;
  int        errors;
  int        checks;
  int        seed;

  exu_decode UUT (.*);

  exu_decode_scoreboard u_sb (.*, .o_errors(errors), .o_checks(checks));

  initial begin
    forever #4 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired, the tests did not finish in time");
    $display("Checks failed");
    $finish;
  end

  function automatic instr_t make_instr(input int kind);
    instr_t w;
    int k;
    int pick;
    int f3;
    w    = $urandom;
    pick = $urandom_range(0, 5);
    k    = (kind == 5) ? $urandom_range(0, 4) : kind;
    if ($urandom_range(0, 3) == 0) w[11:7] = '0; // x0 cases
    if ($urandom_range(0, 3) == 0) w[19:15] = '0;
    if ($urandom_range(0, 3) == 0) w[24:20] = '0;
    case (k)
      0: case (pick)
        0, 1: begin
          w[6:0]   = 7'h33;
          w[31:25] = ($urandom_range(0, 2) == 0) ? 7'h20 : 7'h00;
        end
        2: w[6:0] = 7'h13;
        3: begin
          w[6:0]   = 7'h13; // shift immediate
          w[13:12] = 2'b01;
          w[31:25] = {1'b0, 1'($urandom_range(0, 1)), 5'b0};
        end
        4: w[6:0] = 7'h37;
        default: w[6:0] = 7'h17;
      endcase
      1: w[6:0] = (pick < 3) ? 7'h03 : 7'h23;
      2: case (pick)
        0: w[6:0] = 7'h63;
        1: w[6:0] = 7'h6f;
        2: w[6:0] = 7'h67;
        3: w = 32'h3020_0073;
        4: w = 32'h7b20_0073;
        default: begin
          w[6:0]   = 7'h0f;
          w[14:13] = 2'b00;
        end
      endcase
      3: if (pick < 3) begin
        f3 = $urandom_range(1, 6);
        if (f3 >= 4) f3++;
        w[6:0]   = 7'h73;
        w[14:12] = 3'(f3);
      end else if (pick == 5) begin
        w = (w[0]) ? 32'h1050_0073 : ({31'h0, w[1]} << 20) | 32'h73; // wfi, ecall, ebreak
      end else begin
        w[6:0]   = 7'h33;
        w[31:25] = 7'h01;
      end
      default: case (pick)
        0: w = '0;
        1: w = '1;
        2: begin
          w[6:0]   = 7'h13;
          w[13:12] = 2'b01;
          w[31:25] = 7'h01;
        end
        3: w = 32'h7b20_0073;
        4: w[6:0] = ($urandom_range(0, 1) == 0) ? 7'h0b : 7'h6b; // custom opcodes
        default: w[1:0] = 2'($urandom_range(0, 2));
      endcase
    endcase
    return w;
  endfunction

  task automatic run_test(input string name, input int kind);
    int err0;
    err0 = errors;
    repeat (N_PER) begin
      @(posedge clk);
      i_valid      <= ($urandom_range(0, 3) != 0);
      i_instr      <= make_instr(kind);
      i_pc         <= $urandom;
      i_prdt_taken <= 1'($urandom);
      i_dbg_mode   <= 1'($urandom);
    end
    @(posedge clk);
    i_valid <= 1'b0;
    repeat (2) @(negedge clk);
    $display("test %-10s %0d instructions, %0d mismatches", name, N_PER, errors - err0);
  endtask

  initial begin
    int total;
    seed         = $urandom(32'h976d_d53a);
    i_rst_n      = 1'b1;
    i_valid      = 1'b0;
    i_instr      = '0;
    i_pc         = '0;
    i_prdt_taken = 1'b0;
    i_dbg_mode   = 1'b0;
    #1;
    i_rst_n = 1'b0;
    repeat (3) @(posedge clk);
    i_rst_n <= 1'b1;
    repeat (2) @(negedge clk);
    $display("test %-10s %0d mismatches", "reset", errors);
    run_test("alu", 0);
    run_test("agu", 1);
    run_test("bjp", 2);
    run_test("csr_muldiv", 3);
    run_test("illegal", 4);
    run_test("mixed", 5);
    total = errors + UUT.u_chk.n_fail;
    $display("tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
             N_TESTS, checks, errors, UUT.u_chk.n_fail);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
